/* sources.f */
+incdir+include
src/lsu_pkg.sv
src/lsu_req_split.sv
src/lsu_txn_queue.sv
src/lsu_rdata_align.sv
src/lsu_top.sv
dv/lsu_clk_gen.sv
dv/lsu_assert.sv
dv/lsu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module lsu_tb -f sources.f -o lsu_sim || exit 1
./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || grep -q "=== PASS ===" sim.log

/* dv/lsu_tb.sv */
/*
 * Testbench for the load/store unit.
 * Sends random loads and stores from a fixed seed, serves them with a
 * 64-word bus slave with random grants and 1 to 3 cycle response delays,
 * and checks each result against a byte-addressed reference model.
 * Words 56 to 63 answer with a bus error.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_tb;

  import lsu_pkg::*;

  localparam int NUM_ACC    = 300;
  localparam int MAX_CYCLES = 40 * NUM_ACC;  // Timeout limit

  logic                   clk;
  logic                   rst_n;
  logic                   core_req_valid;
  logic [`LSU_ADDR_W-1:0] core_addr;
  lsu_size_e              core_size;
  logic                   core_we;
  logic                   core_sign_ext;
  logic [`LSU_DATA_W-1:0] core_wdata;
  logic                   core_req_ready;
  logic                   bus_req;
  logic [`LSU_ADDR_W-1:0] bus_addr;
  logic                   bus_we;
  logic [`LSU_BE_W-1:0]   bus_be;
  logic [`LSU_DATA_W-1:0] bus_wdata;
  logic                   bus_gnt;
  logic                   bus_rvalid;
  logic [`LSU_DATA_W-1:0] bus_rdata;
  logic                   bus_err;
  logic                   res_valid;
  logic [`LSU_DATA_W-1:0] res_rdata;
  logic                   res_err;

  integer      seed = 35688;
  logic [31:0] slave_mem [64];    // Bus slave storage
  logic [7:0]  ref_mem [256];     // Byte addressed reference model
  logic [32:0] expected_q [$];    // {err, data} in acceptance order
  logic [32:0] rsp_q [$];         // Slave responses not yet sent
  int          rsp_due_q [$];     // First cycle each response may go out
  int          cyc;
  int          n_issued;
  int          n_accepted;
  int          n_results;
  logic        req_done;          // Accepted on the last edge

  lsu_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top lsu_top_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .core_req_valid_i (core_req_valid),
    .core_addr_i      (core_addr),
    .core_size_i      (core_size),
    .core_we_i        (core_we),
    .core_sign_ext_i  (core_sign_ext),
    .core_wdata_i     (core_wdata),
    .core_req_ready_o (core_req_ready),
    .bus_req_o        (bus_req),
    .bus_addr_o       (bus_addr),
    .bus_we_o         (bus_we),
    .bus_be_o         (bus_be),
    .bus_wdata_o      (bus_wdata),
    .bus_gnt_i        (bus_gnt),
    .bus_rvalid_i     (bus_rvalid),
    .bus_rdata_i      (bus_rdata),
    .bus_err_i        (bus_err),
    .res_valid_o      (res_valid),
    .res_rdata_o      (res_rdata),
    .res_err_o        (res_err)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r[15:0]) % n;
  endfunction

  // Start contents that differ for every word index
  function automatic logic [31:0] fill_word(logic [5:0] w);
    return ({26'd0, w} + 32'd1) * 32'h9e37_79b1;
  endfunction

  function automatic int acc_bytes(lsu_size_e size);
    case (size)
      LSU_SIZE_BYTE: return 1;
      LSU_SIZE_HALF: return 2;
      default:       return 4;
    endcase
  endfunction

  // Any touched byte in words 56..63
  function automatic logic hits_err(logic [7:0] addr, int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++)
    begin
      b = addr + 8'(i);  // Wraps like the slave index
      if (b[7:2] >= 6'd56)
        return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model and slave
  //////////////////////////////////////////////////////////////////////

  task automatic model_access();
    logic [7:0]  b;
    logic [31:0] val;
    int          n;
    n   = acc_bytes(core_size);
    val = '0;                                 // Stores expect zero
    for (int i = 0; i < n; i++)
    begin
      b = core_addr[7:0] + 8'(i);
      if (core_we)
        ref_mem[b] = core_wdata[8*i +: 8];
      else
        val[8*i +: 8] = ref_mem[b];           // Little endian assembly
    end
    if (core_sign_ext && n == 1)
      val = {{24{val[7]}}, val[7:0]};
    if (core_sign_ext && n == 2)
      val = {{16{val[15]}}, val[15:0]};
    expected_q.push_back({hits_err(core_addr[7:0], n), val});
  endtask

  // Read at grant, write enabled lanes, queue the answer
  task automatic serve_grant();
    logic [5:0]  w;
    logic [31:0] word;
    w    = bus_addr[7:2];  // Part two after word 63 lands on word 0
    word = slave_mem[w];
    if (bus_we)
      for (int i = 0; i < 4; i++)
        if (bus_be[i])
          slave_mem[w][8*i +: 8] = bus_wdata[8*i +: 8];
    rsp_q.push_back({(w >= 6'd56), word});
    rsp_due_q.push_back(cyc + 1 + rand_below(3));  // 1 to 3 cycles later
  endtask

  //////////////////////////////////////////////////////////////////////
  // Per-cycle driving and sampling
  //////////////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    if (req_done)
    begin
      core_req_valid = 1'b0;
      req_done       = 1'b0;
    end
    if (rsp_q.size() != 0 && rsp_due_q[0] <= cyc)
    begin
      bus_rvalid           = 1'b1;  // Oldest answer goes first
      {bus_err, bus_rdata} = rsp_q[0];
    end
    else
    begin
      bus_rvalid           = 1'b0;
      {bus_err, bus_rdata} = '0;
    end
    bus_gnt = (rand_below(4) != 0);   // Stall about one cycle in four
    if (!core_req_valid && n_issued < NUM_ACC && rand_below(4) != 0)
    begin
      core_req_valid = 1'b1;
      core_addr      = 32'(rand_below(256));
      case (rand_below(3))
        0:       core_size = LSU_SIZE_BYTE;
        1:       core_size = LSU_SIZE_HALF;
        default: core_size = LSU_SIZE_WORD;
      endcase
      core_we       = (rand_below(2) == 1);
      core_sign_ext = (rand_below(2) == 1);
      core_wdata    = $random(seed);
      n_issued++;
    end
  endtask

  task automatic sample_outputs();
    logic [32:0] exp;
    if (res_valid)
    begin
      assert (expected_q.size() != 0)
      else stop_with_failure("A result came out with no access waiting for it");
      exp = expected_q.pop_front();
      assert (res_rdata === exp[31:0])
      else stop_with_failure($sformatf("Error at time %0t: result data %08h, expected %08h",
                                       $time, res_rdata, exp[31:0]));
      assert (res_err === exp[32])
      else stop_with_failure($sformatf("Error at time %0t: result error %0b, expected %0b",
                                       $time, res_err, exp[32]));
      n_results++;
    end
    if (bus_rvalid)
    begin
      rsp_q.delete(0);
      rsp_due_q.delete(0);
    end
    if (bus_req && bus_gnt)
      serve_grant();
    if (core_req_valid && core_req_ready)
    begin
      model_access();  // Issue order equals acceptance order
      n_accepted++;
      req_done = 1'b1;
    end
    cyc++;
  endtask

  initial
  begin
    logic [31:0] word;
    core_req_valid = 1'b0;
    core_addr      = '0;
    core_size      = LSU_SIZE_BYTE;
    core_we        = 1'b0;
    core_sign_ext  = 1'b0;
    core_wdata     = '0;
    bus_gnt        = 1'b0;
    bus_rvalid     = 1'b0;
    bus_rdata      = '0;
    bus_err        = 1'b0;
    req_done       = 1'b0;
    cyc            = 0;
    n_issued       = 0;
    n_accepted     = 0;
    n_results      = 0;
    for (int w = 0; w < 64; w++)
      slave_mem[w] = fill_word(6'(w));
    for (int b = 0; b < 256; b++)
    begin
      word       = fill_word(6'(b / 4));
      ref_mem[b] = word[8*(b%4) +: 8];
    end
    wait (rst_n === 1'b1);
    // Run until every access is accepted and every bus transfer is answered
    while (n_accepted < NUM_ACC || rsp_q.size() != 0)
    begin
      @(negedge clk);
      drive_inputs();
      @(posedge clk);
      sample_outputs();
    end
    if (n_results == n_accepted && expected_q.size() == 0)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
      stop_with_failure("Result count does not match the accepted access count");
  end

  // Timeout
  initial
  begin
    int n_cycles;
    n_cycles = 0;
    while (n_cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      n_cycles++;
    end
    stop_with_failure($sformatf("Timeout: run did not finish in %0d cycles", MAX_CYCLES));
  end

endmodule

`default_nettype wire

/* dv/lsu_assert.sv */
/*
 * Bus protocol assertions for the load/store unit.
 * Bound into lsu_top; watches the bus request, the grants and the responses.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_assert (
  input wire logic                   clk,
  input wire logic                   rst_n,
  input wire logic                   bus_req_i,
  input wire logic                   bus_gnt_i,
  input wire logic [`LSU_ADDR_W-1:0] bus_addr_i,
  input wire logic                   bus_we_i,
  input wire logic [`LSU_BE_W-1:0]   bus_be_i,
  input wire logic [`LSU_DATA_W-1:0] bus_wdata_i,
  input wire logic                   bus_rvalid_i,
  input wire logic                   txn_busy_i     // Queue holds a record
);

  logic [`LSU_CNT_W:0] outstanding_q;  // Extra bit so an overflow shows

  // Grants minus responses, as seen on the bus
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      outstanding_q <= '0;
    else
      case ({bus_req_i && bus_gnt_i, bus_rvalid_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
  end

  // Waiting request keeps its fields
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_i && !bus_gnt_i) |=> (bus_req_i && $stable(bus_addr_i) && $stable(bus_we_i)
      && $stable(bus_be_i) && $stable(bus_wdata_i)))
    else $error("Bus request dropped or changed before its grant");

  max_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    int'(outstanding_q) <= `LSU_MAX_OUTSTANDING)
    else $error("More bus transfers outstanding than allowed");

  rsp_needs_txn: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> txn_busy_i)
    else $error("Bus response arrived with no transfer outstanding");

endmodule

bind lsu_top lsu_assert u_lsu_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .bus_req_i    (bus_req_o),
  .bus_gnt_i    (bus_gnt_i),
  .bus_addr_i   (bus_addr_o),
  .bus_we_i     (bus_we_o),
  .bus_be_i     (bus_be_o),
  .bus_wdata_i  (bus_wdata_o),
  .bus_rvalid_i (bus_rvalid_i),
  .txn_busy_i   (txn_busy)
);

`default_nettype wire

/* dv/lsu_clk_gen.sv */
/*
 * Testbench clock and reset source.
 * Free-running 20 ns clock, reset held low for the first 3 rising edges.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;  // Released just after the third edge
  end

endmodule

`default_nettype wire

/* src/lsu_top.sv */
/*
 * Load/store unit top level.
 * Core requests enter the splitter, granted transfers are tracked in the
 * queue, and bus responses are turned into one result per access.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_top (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  // Core request
  input  wire logic                    core_req_valid_i,
  input  wire logic [`LSU_ADDR_W-1:0]  core_addr_i,
  input  lsu_pkg::lsu_size_e           core_size_i,
  input  wire logic                    core_we_i,
  input  wire logic                    core_sign_ext_i,
  input  wire logic [`LSU_DATA_W-1:0]  core_wdata_i,
  output logic                         core_req_ready_o,
  // Bus request
  output logic                         bus_req_o,
  output logic [`LSU_ADDR_W-1:0]       bus_addr_o,
  output logic                         bus_we_o,
  output logic [`LSU_BE_W-1:0]         bus_be_o,
  output logic [`LSU_DATA_W-1:0]       bus_wdata_o,
  input  wire logic                    bus_gnt_i,
  // Bus response
  input  wire logic                    bus_rvalid_i,
  input  wire logic [`LSU_DATA_W-1:0]  bus_rdata_i,
  input  wire logic                    bus_err_i,
  // Result
  output logic                         res_valid_o,
  output logic [`LSU_DATA_W-1:0]       res_rdata_o,
  output logic                         res_err_o
);

  import lsu_pkg::*;

  logic     txn_push;   // Granted transfer
  lsu_txn_t txn_data;
  logic     txn_full;   // Outstanding limit reached
  lsu_txn_t txn_head;   // Oldest outstanding transfer
  logic     txn_busy;   // Any transfer outstanding

  lsu_req_split u_req_split (
    .clk              (clk),
    .rst_n            (rst_n),
    .core_req_valid_i (core_req_valid_i),
    .core_addr_i      (core_addr_i),
    .core_size_i      (core_size_i),
    .core_we_i        (core_we_i),
    .core_sign_ext_i  (core_sign_ext_i),
    .core_wdata_i     (core_wdata_i),
    .txn_full_i       (txn_full),
    .bus_gnt_i        (bus_gnt_i),
    .core_req_ready_o (core_req_ready_o),
    .bus_req_o        (bus_req_o),
    .bus_addr_o       (bus_addr_o),
    .bus_we_o         (bus_we_o),
    .bus_be_o         (bus_be_o),
    .bus_wdata_o      (bus_wdata_o),
    .txn_push_o       (txn_push),
    .txn_data_o       (txn_data)
  );

  lsu_txn_queue #(
    .DEPTH (`LSU_MAX_OUTSTANDING)
  ) u_txn_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (txn_push),
    .push_data_i (txn_data),
    .pop_i       (bus_rvalid_i),  // Responses come back in order
    .full_o      (txn_full),
    .head_o      (txn_head),
    .busy_o      (txn_busy)
  );

  lsu_rdata_align u_rdata_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .rvalid_i    (bus_rvalid_i),
    .rdata_i     (bus_rdata_i),
    .err_i       (bus_err_i),
    .txn_i       (txn_head),
    .res_valid_o (res_valid_o),
    .res_rdata_o (res_rdata_o),
    .res_err_o   (res_err_o)
  );

endmodule

`default_nettype wire

/* src/lsu_rdata_align.sv */
/*
 * Response side of the load/store unit.
 * Saves the first word of a split load, assembles the access from one or
 * two bus words, picks the byte/halfword/word at the offset and extends it.
 * Errors of all parts are merged into the single result of the access.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_rdata_align (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    rvalid_i,
  input  wire logic [`LSU_DATA_W-1:0]  rdata_i,
  input  wire logic                    err_i,
  input  lsu_pkg::lsu_txn_t            txn_i,      // Record of the answered transfer
  output logic                         res_valid_o,
  output logic [`LSU_DATA_W-1:0]       res_rdata_o,
  output logic                         res_err_o
);

  import lsu_pkg::*;

  logic [`LSU_DATA_W-1:0]   rdata_q;     // Lower word of a split load
  logic                     err_q;       // Error seen on the first part
  logic                     split;
  logic [2*`LSU_DATA_W-1:0] src;         // Upper word new, lower word saved
  logic [2*`LSU_DATA_W-1:0] shifted;
  logic [`LSU_DATA_W-1:0]   ext;

  assign split = lsu_is_split(txn_i.size, txn_i.offset);

  //////////////////////////////////////////////////////////////////////
  // First part capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rvalid_i && !txn_i.last && !txn_i.we)
      rdata_q <= rdata_i;  // Raw word whose upper bytes are used later
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      err_q <= 1'b0;
    else if (rvalid_i)
      err_q <= txn_i.last ? 1'b0 : err_i;  // Cleared once the access completes
  end

  //////////////////////////////////////////////////////////////////////
  // Assembly and extension
  //////////////////////////////////////////////////////////////////////

  // Split access puts the new word above the saved one before the shift down
  assign src     = split ? {rdata_i, rdata_q} : {{`LSU_DATA_W{1'b0}}, rdata_i};
  assign shifted = src >> {txn_i.offset, 3'b000};

  always_comb
  begin
    case (txn_i.size)
      LSU_SIZE_BYTE: ext = {{24{txn_i.sign_ext & shifted[7]}}, shifted[7:0]};
      LSU_SIZE_HALF: ext = {{16{txn_i.sign_ext & shifted[15]}}, shifted[15:0]};
      default:       ext = shifted[31:0];  // Word needs no extension
    endcase
  end

  assign res_valid_o = rvalid_i && txn_i.last;   // One result per access
  assign res_rdata_o = txn_i.we ? '0 : ext;      // Stores return zero
  assign res_err_o   = res_valid_o && (err_i || err_q);

endmodule

`default_nettype wire

/* src/lsu_txn_queue.sv */
/*
 * In-order queue of tracking records for outstanding bus transfers.
 * Push on every grant, pop on every response. The count of entries
 * doubles as the outstanding-transfer limit seen by the request side.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_txn_queue #(
  parameter int DEPTH = `LSU_MAX_OUTSTANDING
) (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           push_i,       // Transfer granted
  input  lsu_pkg::lsu_txn_t   push_data_i,
  input  wire logic           pop_i,        // Response received
  output logic                full_o,
  output lsu_pkg::lsu_txn_t   head_o,       // Record of the oldest transfer
  output logic                busy_o
);

  import lsu_pkg::*;

  // Counter grows with DEPTH beyond the default width
  localparam int CNT_W = ($clog2(DEPTH + 1) > `LSU_CNT_W) ? $clog2(DEPTH + 1) : `LSU_CNT_W;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  lsu_txn_t         mem_q [DEPTH];  // Record storage
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;          // Outstanding transfers

  assign full_o = (cnt_q == CNT_FULL);
  assign busy_o = (cnt_q != '0);
  assign head_o = mem_q[rd_ptr_q];

  // Pointers and count
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // Idle, or grant and response together
      endcase
    end
  end

  // Record write
  always_ff @(posedge clk)
  begin
    if (push_i)
      mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

`default_nettype wire

/* src/lsu_req_split.sv */
/*
 * Request side of the load/store unit.
 * Turns one core access into one or two bus transfers, builds the byte
 * enables and lane-rotated store data, and pushes a tracking record for
 * every granted transfer. The core request is acknowledged with the last grant.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_req_split (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    core_req_valid_i,
  input  wire logic [`LSU_ADDR_W-1:0]  core_addr_i,
  input  lsu_pkg::lsu_size_e           core_size_i,
  input  wire logic                    core_we_i,
  input  wire logic                    core_sign_ext_i,
  input  wire logic [`LSU_DATA_W-1:0]  core_wdata_i,
  input  wire logic                    txn_full_i,       // No free tracking slot
  input  wire logic                    bus_gnt_i,
  output logic                         core_req_ready_o,
  output logic                         bus_req_o,
  output logic [`LSU_ADDR_W-1:0]       bus_addr_o,
  output logic                         bus_we_o,
  output logic [`LSU_BE_W-1:0]         bus_be_o,
  output logic [`LSU_DATA_W-1:0]       bus_wdata_o,
  output logic                         txn_push_o,
  output lsu_pkg::lsu_txn_t            txn_data_o
);

  import lsu_pkg::*;

  logic [1:0] offset;       // Byte offset inside the word
  logic       split;        // Access needs two transfers
  logic       phase_q;      // Second part of a split access pending
  logic       granted;      // Transfer accepted by the bus
  logic       last_part;    // Current transfer finishes the access

  assign offset    = core_addr_i[1:0];
  assign split     = lsu_is_split(core_size_i, offset);
  assign last_part = !split || phase_q;

  //////////////////////////////////////////////////////////////////////
  // Bus request
  //////////////////////////////////////////////////////////////////////

  // Held low while the queue is full, even if a response frees a slot now
  assign bus_req_o = core_req_valid_i && !txn_full_i;
  assign granted   = bus_req_o && bus_gnt_i;

  // Second part goes to the next word, lane 0 upward
  assign bus_addr_o = phase_q ? {core_addr_i[`LSU_ADDR_W-1:2] + 1'b1, 2'b00} : core_addr_i;
  assign bus_we_o   = core_we_i;

  // Byte enables
  always_comb
  begin
    bus_be_o = 4'b0000;
    case (core_size_i)
      LSU_SIZE_BYTE: bus_be_o = 4'b0001 << offset;
      LSU_SIZE_HALF:
      begin
        if (phase_q)
          bus_be_o = 4'b0001;                        // Upper byte of offset-3 half
        else
          bus_be_o = (4'b0011 << offset);            // Offset 3 leaves only lane 3
      end
      LSU_SIZE_WORD:
      begin
        if (phase_q)
          bus_be_o = ~(4'b1111 << offset);           // Remaining low lanes
        else
          bus_be_o = (4'b1111 << offset);
      end
      default: bus_be_o = 4'b0000;
    endcase
  end

  // Store data moved so byte 0 lands on the lane at the offset; same data for both parts
  always_comb
  begin
    case (offset)
      2'b00:   bus_wdata_o = core_wdata_i;
      2'b01:   bus_wdata_o = {core_wdata_i[23:0], core_wdata_i[31:24]};
      2'b10:   bus_wdata_o = {core_wdata_i[15:0], core_wdata_i[31:16]};
      default: bus_wdata_o = {core_wdata_i[7:0], core_wdata_i[31:8]};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Phase and tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      phase_q <= 1'b0;
    else if (granted)
      phase_q <= split && !phase_q;  // First grant of a split access moves to part two
  end

  assign core_req_ready_o = granted && last_part;  // Access done with its last grant

  assign txn_push_o = granted;

  always_comb
  begin
    txn_data_o.size     = core_size_i;
    txn_data_o.sign_ext = core_sign_ext_i;
    txn_data_o.we       = core_we_i;
    txn_data_o.offset   = offset;
    txn_data_o.last     = last_part;
  end

endmodule

`default_nettype wire

/* src/lsu_pkg.sv */
/*
 * Types shared by the load/store unit blocks.
 * Holds the access size encoding, the per-transfer tracking record
 * and the split-access rule used on both the request and response side.
 */
`default_nettype none

package lsu_pkg;

  typedef enum logic [1:0] {
    LSU_SIZE_BYTE = 2'd0,
    LSU_SIZE_HALF = 2'd1,
    LSU_SIZE_WORD = 2'd2
  } lsu_size_e;

  // Tracking record, one per granted bus transfer
  typedef struct packed {
    lsu_size_e  size;      // Access size of the whole access
    logic       sign_ext;  // Sign extend load result
    logic       we;        // Store
    logic [1:0] offset;    // Low address bits of the original access
    logic       last;      // Only or second part of the access
  } lsu_txn_t;

  // Access crosses a word boundary and needs two transfers
  function automatic logic lsu_is_split(lsu_size_e size, logic [1:0] offset);
    return ((size == LSU_SIZE_WORD) && (offset != 2'b00)) ||
           ((size == LSU_SIZE_HALF) && (offset == 2'b11));
  endfunction

endpackage

`default_nettype wire

/* include/lsu_settings.svh */
/*
 * Global sizes for the load/store unit.
 * Include in any file that needs bus widths or the outstanding limit.
 * The counter width must hold values 0 up to LSU_MAX_OUTSTANDING.
 */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

`define LSU_ADDR_W          32  // Byte address
`define LSU_DATA_W          32  // One bus word
`define LSU_BE_W            4   // One enable per byte lane

// Transfers granted but not yet answered
`define LSU_MAX_OUTSTANDING 2
`define LSU_CNT_W           2   // Outstanding counter width

`endif
